// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

  // address and data widths
  localparam int unsigned XLEN   = 64;
  localparam int unsigned ILEN   = 32;
  localparam int unsigned AXI_DW = 64;

  // first fetch address after reset
  localparam logic [XLEN-1:0] PC_RESET = 64'h0000_0000_8000_0000;

  // rom geometry, word index comes from pc[6:2]
  localparam int unsigned ROM_WORDS = 32;
  localparam int unsigned ROM_IDX_W = $clog2(ROM_WORDS);
  localparam string       ROM_FILE  = "prog.hex";

  // cycles from ar handshake to r valid
  localparam int unsigned ROM_LAT   = 2;
  localparam int unsigned LAT_CNT_W = $clog2(ROM_LAT + 1);

  // addi x0,x0,0
  localparam logic [ILEN-1:0] INST_NOP = 32'h0000_0013;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // pc_gen -> request stage -> master
  typedef struct packed {
    logic [XLEN-1:0] pc;
  } fetch_req_t;

  // read address channel, single beat only
  typedef struct packed {
    logic [XLEN-1:0] addr;
  } axi_ar_t;

  // read data channel
  typedef struct packed {
    logic [AXI_DW-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } axi_r_t;

  // fetched instruction with its pc, towards decode
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [ILEN-1:0] inst;
  } fetch_out_t;

endpackage

// ==== hdl/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen (
  input  logic                      clk,
  input  logic                      rst_n,
  // branch / jalr target from decode
  input  logic                      redirect_i,
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  // long-latency ops in flight
  input  logic                      mul_pend_i,
  input  logic                      mul_done_i,
  input  logic                      div_pend_i,
  input  logic                      div_done_i,
  // request towards the request stage
  output logic                      req_valid_o,
  input  logic                      req_ready_i,
  output fetch_pkg::fetch_req_t     req_o
);

  import fetch_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic            stall;
  logic            req_hs;

  // hold fetch while mul or div is pending and not done
  assign stall = (mul_pend_i & ~mul_done_i) | (div_pend_i & ~div_done_i);

  // valid is purely combinational, no registered state needed
  assign req_valid_o = ~stall;
  assign req_hs      = req_valid_o & req_ready_i;

  // pc update
  // redirect wins over a handshake in the same cycle,
  // and is taken even while stalled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= PC_RESET;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (req_hs) begin
      // sequential advance, no prediction
      pc_q <= pc_q + XLEN'(4);
    end
  end

  assign req_o.pc = pc_q;

endmodule

// ==== hdl/fetch_stage_reg.sv ====
`timescale 1ns/1ps

module fetch_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  // drop held item
  input  logic     flush_i,
  // upstream side
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  // downstream side
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;
  payload_t data_q;

  // take a new item when empty or when the current one leaves this cycle
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      // flush also discards anything loaded this cycle
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // payload only, held while downstream stalls
  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

// ==== hdl/axi_rd_master.sv ====
`timescale 1ns/1ps

module axi_rd_master (
  input  logic                  clk,
  input  logic                  rst_n,
  // kill the read in flight
  input  logic                  redirect_i,
  // fetch request in
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  fetch_pkg::fetch_req_t req_i,
  // AR channel
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output fetch_pkg::axi_ar_t    ar_o,
  // R channel
  input  logic                  r_valid_i,
  output logic                  r_ready_o,
  input  fetch_pkg::axi_r_t     r_i,
  // fetched instruction out
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output fetch_pkg::fetch_out_t out_o
);

  import fetch_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_t;

  state_t          state_q;
  logic [XLEN-1:0] pc_q;
  logic            kill_q;
  logic            req_hs;
  logic            r_hs;

  // one read at a time
  // only start when the output stage can take the beat
  assign req_ready_o = (state_q == ST_IDLE) & out_ready_i;
  assign req_hs      = req_valid_i & req_ready_o;

  assign ar_valid_o = (state_q == ST_ADDR);
  assign ar_o.addr  = pc_q;

  // a killed beat is swallowed regardless of the output stage
  assign r_ready_o = (state_q == ST_DATA) & (kill_q | out_ready_i);
  assign r_hs      = r_valid_i & r_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      kill_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_hs) begin
            state_q <= ST_ADDR;
            // request taken in a redirect cycle is already stale
            kill_q  <= redirect_i;
          end
        end
        ST_ADDR: begin
          if (redirect_i) begin
            kill_q <= 1'b1;
          end
          if (ar_ready_i) begin
            state_q <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (redirect_i) begin
            kill_q <= 1'b1;
          end
          if (r_hs) begin
            state_q <= ST_IDLE;
            kill_q  <= 1'b0;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // pc of the read in flight, stable through addr and data states
  always_ff @(posedge clk) begin
    if (req_hs) begin
      pc_q <= req_i.pc;
    end
  end

  // beat goes straight to the output stage on the r handshake
  assign out_valid_o = r_hs & ~kill_q & ~redirect_i;
  assign out_o.pc    = pc_q;
  // pc[2] picks the upper word of the doubleword
  assign out_o.inst  = pc_q[2] ? r_i.data[AXI_DW-1 -: ILEN] : r_i.data[ILEN-1:0];

endmodule

// ==== hdl/inst_rom_slave.sv ====
`timescale 1ns/1ps

module inst_rom_slave (
  input  logic               clk,
  input  logic               rst_n,
  // AR channel
  input  logic               ar_valid_i,
  output logic               ar_ready_o,
  input  fetch_pkg::axi_ar_t ar_i,
  // R channel
  output logic               r_valid_o,
  input  logic               r_ready_i,
  output fetch_pkg::axi_r_t  r_o
);

  import fetch_pkg::*;

  // program image, one instruction word per entry
  logic [ILEN-1:0] rom [ROM_WORDS];

  initial begin
    $readmemh(ROM_FILE, rom);
  end

  logic                 busy_q;
  logic [LAT_CNT_W-1:0] cnt_q;
  logic [AXI_DW-1:0]    data_q;
  logic                 ar_hs;
  logic [ROM_IDX_W-1:0] idx_lo;
  logic [ROM_IDX_W-1:0] idx_hi;

  // accept a new address only when no response pending
  assign ar_ready_o = ~busy_q;
  assign ar_hs      = ar_valid_i & ar_ready_o;

  // doubleword aligned pair of words, wraps on the rom size
  assign idx_lo = {ar_i.addr[ROM_IDX_W+1:3], 1'b0};
  assign idx_hi = {ar_i.addr[ROM_IDX_W+1:3], 1'b1};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (ar_hs) begin
      busy_q <= 1'b1;
      // counts down to zero, response shows at zero
      cnt_q  <= LAT_CNT_W'(ROM_LAT - 1);
    end else if (busy_q) begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else if (r_ready_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // read the rom at the address handshake
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      data_q <= {rom[idx_hi], rom[idx_lo]};
    end
  end

  // valid held until the master takes it
  assign r_valid_o = busy_q & (cnt_q == '0);

  // single beat, always okay
  assign r_o.data = data_q;
  assign r_o.resp = RESP_OKAY;
  assign r_o.last = 1'b1;

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
  input  logic                       clk,
  input  logic                       rst_n,
  // redirect from decode
  input  logic                       redirect_i,
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  // mul/div stall flags
  input  logic                       mul_pend_i,
  input  logic                       mul_done_i,
  input  logic                       div_pend_i,
  input  logic                       div_done_i,
  // decode side
  input  logic                       dec_ready_i,
  output logic                       inst_valid_o,
  output logic [fetch_pkg::ILEN-1:0] inst_o,
  output logic [fetch_pkg::XLEN-1:0] inst_pc_o
);

  import fetch_pkg::*;

  // pc_gen -> request stage
  logic       pc_valid;
  logic       pc_ready;
  fetch_req_t pc_req;

  // request stage -> master
  logic       req_valid;
  logic       req_ready;
  fetch_req_t req;

  // master <-> rom
  logic       ar_valid;
  logic       ar_ready;
  axi_ar_t    ar;
  logic       r_valid;
  logic       r_ready;
  axi_r_t     r;

  // master -> output stage
  logic       beat_valid;
  logic       beat_ready;
  fetch_out_t beat;
  fetch_out_t out_data;

  pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .mul_pend_i    (mul_pend_i),
    .mul_done_i    (mul_done_i),
    .div_pend_i    (div_pend_i),
    .div_done_i    (div_done_i),
    .req_valid_o   (pc_valid),
    .req_ready_i   (pc_ready),
    .req_o         (pc_req)
  );

  // redirect flushes both holding stages
  fetch_stage_reg #(.payload_t(fetch_req_t)) u_req_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect_i),
    .in_valid_i  (pc_valid),
    .in_ready_o  (pc_ready),
    .in_data_i   (pc_req),
    .out_valid_o (req_valid),
    .out_ready_i (req_ready),
    .out_data_o  (req)
  );

  axi_rd_master u_axi_rd_master (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect_i  (redirect_i),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_i       (req),
    .ar_valid_o  (ar_valid),
    .ar_ready_i  (ar_ready),
    .ar_o        (ar),
    .r_valid_i   (r_valid),
    .r_ready_o   (r_ready),
    .r_i         (r),
    .out_valid_o (beat_valid),
    .out_ready_i (beat_ready),
    .out_o       (beat)
  );

  inst_rom_slave u_inst_rom_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_i       (ar),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .r_o        (r)
  );

  fetch_stage_reg #(.payload_t(fetch_out_t)) u_out_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect_i),
    .in_valid_i  (beat_valid),
    .in_ready_o  (beat_ready),
    .in_data_i   (beat),
    .out_valid_o (inst_valid_o),
    .out_ready_i (dec_ready_i),
    .out_data_o  (out_data)
  );

  // decode sees a nop bubble when nothing is valid
  assign inst_o    = inst_valid_o ? out_data.inst : INST_NOP;
  assign inst_pc_o = out_data.pc;

endmodule

// ==== sim/fetch_props.sv ====
`timescale 1ns/1ps

module fetch_props (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       redirect_i,
  input logic                       dec_ready_i,
  input logic                       inst_valid_i,
  input logic [fetch_pkg::ILEN-1:0] inst_i,
  input logic [fetch_pkg::XLEN-1:0] inst_pc_i,
  input logic                       ar_valid_i,
  input logic                       ar_ready_i,
  input fetch_pkg::axi_ar_t         ar_i,
  input logic                       r_valid_i,
  input fetch_pkg::axi_r_t          r_i
);

  import fetch_pkg::*;

  // count of failed assertions
  int unsigned fail_cnt = 0;

  // AR only drops once the slave has taken it
  ar_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(ar_valid_i) |-> $past(ar_ready_i))
  else begin
    $error("ar_valid dropped before ar_ready");
    fail_cnt++;
  end

  // empty output shows a nop bubble
  nop_a: assert property (@(posedge clk) disable iff (!rst_n)
    !inst_valid_i |-> inst_i == INST_NOP)
  else begin
    $error("inst_o is not a nop while inst_valid_o is low");
    fail_cnt++;
  end

  // held for decode unless a redirect flushes it
  hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_i && !dec_ready_i && !redirect_i |=>
      inst_valid_i && $stable(inst_i) && $stable(inst_pc_i))
  else begin
    $error("output changed while decode applied back-pressure");
    fail_cnt++;
  end

  // rom answers every read with okay
  resp_a: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid_i |-> r_i.resp == RESP_OKAY)
  else begin
    $error("read response is not okay");
    fail_cnt++;
  end

endmodule

// ==== sim/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

  import fetch_pkg::*;

  // instructions requested per phase
  localparam int unsigned N_SEQ      = 40;
  localparam int unsigned N_BP       = 30;
  localparam int unsigned N_REDIR    = 8;
  localparam int unsigned N_STALL    = 6;
  localparam int unsigned N_INSTR    = N_SEQ + N_BP + N_REDIR * 4 + N_STALL * 6;
  // 5 cycles per instruction times 4 for random back-pressure
  localparam int unsigned MAX_CYCLES = 5 * N_INSTR * 4 + 200;

  logic            clk;
  logic            rst_n;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;
  logic            mul_pend;
  logic            mul_done;
  logic            div_pend;
  logic            div_done;
  logic            dec_ready;
  logic            inst_valid;
  logic [ILEN-1:0] inst;
  logic [XLEN-1:0] inst_pc;

  // reference image and expected stream
  logic [ILEN-1:0] rom_model [ROM_WORDS];
  logic [XLEN-1:0] exp_pc;
  logic [31:0]     rng;
  logic            stall_win;
  int unsigned     delivered;
  int unsigned     stall_base;
  int unsigned     gap;
  int unsigned     checks;
  int unsigned     errors;
  int unsigned     prop_fails;
  int unsigned     cycles;

  fetch_top u_fetch_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .mul_pend_i    (mul_pend),
    .mul_done_i    (mul_done),
    .div_pend_i    (div_pend),
    .div_done_i    (div_done),
    .dec_ready_i   (dec_ready),
    .inst_valid_o  (inst_valid),
    .inst_o        (inst),
    .inst_pc_o     (inst_pc)
  );

  // protocol checks on the top ports and the inner AXI channels
  bind fetch_top fetch_props u_fetch_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect_i   (redirect_i),
    .dec_ready_i  (dec_ready_i),
    .inst_valid_i (inst_valid_o),
    .inst_i       (inst_o),
    .inst_pc_i    (inst_pc_o),
    .ar_valid_i   (ar_valid),
    .ar_ready_i   (ar_ready),
    .ar_i         (ar),
    .r_valid_i    (r_valid),
    .r_i          (r)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift_next(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // output must be empty with a nop on the instruction bus
  task automatic check_idle_output();
    assert (!inst_valid) else begin
      $display("error: %0d ns inst_valid_o got %b expected 0", $time, inst_valid);
      errors = errors + 1;
    end
    assert (inst == INST_NOP) else begin
      $display("error: %0d ns inst_o got %h expected %h", $time, inst, INST_NOP);
      errors = errors + 1;
    end
    checks = checks + 2;
  endtask

  // random dec_ready until enough instructions came out
  task automatic deliver_until(input int unsigned target, input int unsigned bp_pct);
    while (delivered < target) begin
      @(negedge clk);
      rng       = xorshift_next(rng);
      dec_ready = (rng % 32'd100) >= bp_pct;
    end
  endtask

  // decode takes an instruction on valid and ready
  always @(posedge clk) begin
    if (rst_n && inst_valid && dec_ready) begin
      assert (inst_pc == exp_pc) else begin
        $display("error: %0d ns inst_pc_o got %h expected %h", $time, inst_pc, exp_pc);
        errors = errors + 1;
      end
      // word index from pc[6:2] wraps with the image
      assert (inst == rom_model[exp_pc[ROM_IDX_W+1:2]]) else begin
        $display("error: %0d ns inst_o got %h expected %h", $time, inst,
                 rom_model[exp_pc[ROM_IDX_W+1:2]]);
        errors = errors + 1;
      end
      checks    = checks + 2;
      exp_pc    = exp_pc + 64'd4;
      delivered = delivered + 1;
    end
    // old path ends with this edge
    if (rst_n && redirect) begin
      exp_pc = redirect_pc;
    end
    // at most request stage plus read or output stage still drain
    if (stall_win) begin
      assert (delivered - stall_base <= 2) else begin
        $display("error: %0d ns delivered during stall got %0d expected at most 2",
                 $time, delivered - stall_base);
        errors = errors + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles, %0d of %0d instructions delivered",
               cycles, delivered, N_INSTR);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    rng         = 32'd82;
    rst_n       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    mul_pend    = 1'b0;
    mul_done    = 1'b0;
    div_pend    = 1'b0;
    div_done    = 1'b0;
    dec_ready   = 1'b1;
    exp_pc      = PC_RESET;
    stall_win   = 1'b0;
    delivered   = 0;
    stall_base  = 0;
    gap         = 0;
    checks      = 0;
    errors      = 0;
    prop_fails  = 0;
    cycles      = 0;
    $readmemh(ROM_FILE, rom_model);

    // two reset cycles and a few more with nothing in the output
    repeat (2) begin
      @(negedge clk);
      check_idle_output();
    end
    rst_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_idle_output();
    end

    // 40 words runs past the 32 word wrap
    deliver_until(N_SEQ, 0);
    deliver_until(N_SEQ + N_BP, 40);

    // redirect at random points of the read
    for (int i = 0; i < N_REDIR; i++) begin
      rng = xorshift_next(rng);
      gap = rng % 32'd6;
      repeat (gap) begin
        @(negedge clk);
        rng       = xorshift_next(rng);
        dec_ready = rng[0] | rng[1];
      end
      @(negedge clk);
      rng         = xorshift_next(rng);
      redirect    = 1'b1;
      redirect_pc = PC_RESET + {57'd0, rng[4:0], 2'b00};
      dec_ready   = rng[7];
      @(negedge clk);
      redirect = 1'b0;
      deliver_until(delivered + 4, 30);
    end

    // mul or div hold followed by one cycle of done
    for (int i = 0; i < N_STALL; i++) begin
      @(negedge clk);
      rng        = xorshift_next(rng);
      stall_base = delivered;
      stall_win  = 1'b1;
      mul_pend   = rng[0];
      div_pend   = ~rng[0];
      gap        = 3 + (rng >> 8) % 32'd12;
      repeat (gap) begin
        @(negedge clk);
        rng       = xorshift_next(rng);
        dec_ready = rng[2] | rng[5];
      end
      @(negedge clk);
      stall_win = 1'b0;
      mul_done  = mul_pend;
      div_done  = div_pend;
      @(negedge clk);
      mul_pend = 1'b0;
      div_pend = 1'b0;
      mul_done = 1'b0;
      div_done = 1'b0;
      deliver_until(delivered + 6, 20);
    end

    prop_fails = u_fetch_top.u_fetch_props.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== prog.hex ====
// one 32-bit instruction word per line, word index 0 to 31
// each word is addi x1,x1,n with n = index + 1
00108093
00208093
00308093
00408093
00508093
00608093
00708093
00808093
00908093
00a08093
00b08093
00c08093
00d08093
00e08093
00f08093
01008093
01108093
01208093
01308093
01408093
01508093
01608093
01708093
01808093
01908093
01a08093
01b08093
01c08093
01d08093
01e08093
01f08093
02008093

// ==== verilog.f ====
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/fetch_stage_reg.sv
hdl/axi_rd_master.sv
hdl/inst_rom_slave.sv
hdl/fetch_top.sv
sim/fetch_props.sv
sim/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator, verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
  -f verilog.f -o fetch_sim || { echo "build failed"; exit 1; }
./obj_dir/fetch_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "result: fail"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "result: no verdict in sim.log"; exit 1; }
echo "result: pass"
